//--- tb.f
rtl/axi_pkg.sv
rtl/xbar_pkg.sv
rtl/ar_arbiter.sv
rtl/ar_issue.sv
rtl/decerr_slave.sv
rtl/r_router.sv
rtl/axi_rd_xbar.sv
tests/tb_slave_model.sv
tests/tb_axi_rd_xbar.sv

//--- run.sh
#!/bin/sh
# Compile with Verilator and run; the exit status reports pass or fail
set -e

cd "$(dirname "$0")"

verilator --binary -f tb.f --top-module tb_axi_rd_xbar -o tb_axi_rd_xbar

./obj_dir/tb_axi_rd_xbar

//--- tests/tb_axi_rd_xbar.sv
`timescale 1ns/10ps

module tb_axi_rd_xbar;
	import axi_pkg::*;

	localparam int     CLK_PERIOD       = 8;
	localparam int     SEED             = 44870;
	localparam int     READS_PER_MASTER = 100;
	localparam int     MAX_BEATS        = 8;
	localparam int     TIMEOUT_CYCLES   = 40 * MAX_BEATS * 2 * READS_PER_MASTER;
	localparam addr_t  SLAVE1_BASE      = 32'h0001_0000;
	localparam addr_t  DECODE_LIMIT     = 32'h0002_0000;
	localparam data_t  S0_SALT          = 32'h0000_0000;
	localparam data_t  S1_SALT          = 32'hA5A5_0000;

	typedef struct packed {
		mid_t  id;
		data_t data;
		resp_t resp;
		logic  last;
	} beat_t;

	logic   ACLK;
	logic   ARESETn;

	addr_t  araddr_m0, araddr_m1;
	mid_t   arid_m0, arid_m1;
	len_t   arlen_m0, arlen_m1;
	size_t  arsize_m0, arsize_m1;
	burst_t arburst_m0, arburst_m1;
	logic   arvalid_m0, arvalid_m1;
	logic   arready_m0, arready_m1;
	mid_t   rid_m0, rid_m1;
	data_t  rdata_m0, rdata_m1;
	resp_t  rresp_m0, rresp_m1;
	logic   rlast_m0, rlast_m1;
	logic   rvalid_m0, rvalid_m1;
	logic   rready_m0, rready_m1;

	addr_t  araddr_s0, araddr_s1;
	sid_t   arid_s0, arid_s1;
	len_t   arlen_s0, arlen_s1;
	size_t  arsize_s0, arsize_s1;
	burst_t arburst_s0, arburst_s1;
	logic   arvalid_s0, arvalid_s1;
	logic   arready_s0, arready_s1;
	sid_t   rid_s0, rid_s1;
	data_t  rdata_s0, rdata_s1;
	resp_t  rresp_s0, rresp_s1;
	logic   rlast_s0, rlast_s1;
	logic   rvalid_s0, rvalid_s1;
	logic   rready_s0, rready_s1;

	// ====================
	// Failure reporting
	// ====================
	task automatic stop_on_failure();
		$display("sim failed");
		$fatal(1, "run aborted");
	endtask

	task automatic check_data(input data_t got, input data_t exp, input string what);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
			stop_on_failure();
		end
	endtask

	task automatic check_resp(input resp_t got, input resp_t exp, input string what);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
			stop_on_failure();
		end
	endtask

	task automatic check_id(input mid_t got, input mid_t exp, input string what);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
			stop_on_failure();
		end
	endtask

	task automatic check_last(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
			stop_on_failure();
		end
	endtask

	task automatic check_size(input size_t got, input size_t exp, input string what);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp);
			stop_on_failure();
		end
	endtask

	task automatic check_burst(input burst_t got, input burst_t exp, input string what);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp);
			stop_on_failure();
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
			stop_on_failure();
		end
	endtask

	task automatic check_reset_levels();
		check_flag(arready_m0, 1'b0, "arready_m0 after reset");
		check_flag(arready_m1, 1'b0, "arready_m1 after reset");
		check_flag(rvalid_m0, 1'b0, "rvalid_m0 after reset");
		check_flag(rvalid_m1, 1'b0, "rvalid_m1 after reset");
	endtask

	// ====================
	// Reference model
	// ====================
	function automatic addr_t pick_addr(input int region);
		addr_t off;
		off = addr_t'($urandom) & 32'h0000_FFFC;
		// Hit the range edges now and then
		if (($urandom % 8) == 0) begin
			off = (($urandom % 2) == 0) ? 32'h0000_0000 : 32'h0000_FFFC;
		end
		case (region)
			0: return off;
			1: return SLAVE1_BASE + off;
			default: return DECODE_LIMIT + (off << ($urandom % 16));
		endcase
	endfunction

	function automatic beat_t expected_beat(input addr_t base, input mid_t id, input len_t len,
	                                        input int idx);
		beat_t b;
		addr_t beat_addr;
		beat_addr = base + addr_t'(BEAT_BYTES * idx);
		b.id   = id;
		b.last = (idx == int'(len));
		if (base < SLAVE1_BASE) begin
			b.data = beat_addr ^ S0_SALT;
			b.resp = RESP_OKAY;
		end else if (base < DECODE_LIMIT) begin
			b.data = beat_addr ^ S1_SALT;
			b.resp = RESP_OKAY;
		end else begin
			b.data = '0;
			b.resp = RESP_DECERR;
		end
		return b;
	endfunction

	// ====================
	// DUT and slaves
	// ====================
	axi_rd_xbar #(
		.SLAVE1_BASE  (SLAVE1_BASE),
		.DECODE_LIMIT (DECODE_LIMIT)
	) axi_rd_xbar_inst (
		.ACLK       (ACLK),
		.ARESETn    (ARESETn),
		.araddr_m0  (araddr_m0),
		.arid_m0    (arid_m0),
		.arlen_m0   (arlen_m0),
		.arsize_m0  (arsize_m0),
		.arburst_m0 (arburst_m0),
		.arvalid_m0 (arvalid_m0),
		.arready_m0 (arready_m0),
		.rid_m0     (rid_m0),
		.rdata_m0   (rdata_m0),
		.rresp_m0   (rresp_m0),
		.rlast_m0   (rlast_m0),
		.rvalid_m0  (rvalid_m0),
		.rready_m0  (rready_m0),
		.araddr_m1  (araddr_m1),
		.arid_m1    (arid_m1),
		.arlen_m1   (arlen_m1),
		.arsize_m1  (arsize_m1),
		.arburst_m1 (arburst_m1),
		.arvalid_m1 (arvalid_m1),
		.arready_m1 (arready_m1),
		.rid_m1     (rid_m1),
		.rdata_m1   (rdata_m1),
		.rresp_m1   (rresp_m1),
		.rlast_m1   (rlast_m1),
		.rvalid_m1  (rvalid_m1),
		.rready_m1  (rready_m1),
		.araddr_s0  (araddr_s0),
		.arid_s0    (arid_s0),
		.arlen_s0   (arlen_s0),
		.arsize_s0  (arsize_s0),
		.arburst_s0 (arburst_s0),
		.arvalid_s0 (arvalid_s0),
		.arready_s0 (arready_s0),
		.rid_s0     (rid_s0),
		.rdata_s0   (rdata_s0),
		.rresp_s0   (rresp_s0),
		.rlast_s0   (rlast_s0),
		.rvalid_s0  (rvalid_s0),
		.rready_s0  (rready_s0),
		.araddr_s1  (araddr_s1),
		.arid_s1    (arid_s1),
		.arlen_s1   (arlen_s1),
		.arsize_s1  (arsize_s1),
		.arburst_s1 (arburst_s1),
		.arvalid_s1 (arvalid_s1),
		.arready_s1 (arready_s1),
		.rid_s1     (rid_s1),
		.rdata_s1   (rdata_s1),
		.rresp_s1   (rresp_s1),
		.rlast_s1   (rlast_s1),
		.rvalid_s1  (rvalid_s1),
		.rready_s1  (rready_s1)
	);

	tb_slave_model #(.SALT(S0_SALT)) slave0 (
		.ACLK    (ACLK),
		.ARESETn (ARESETn),
		.araddr  (araddr_s0),
		.arid    (arid_s0),
		.arlen   (arlen_s0),
		.arvalid (arvalid_s0),
		.arready (arready_s0),
		.rid     (rid_s0),
		.rdata   (rdata_s0),
		.rresp   (rresp_s0),
		.rlast   (rlast_s0),
		.rvalid  (rvalid_s0),
		.rready  (rready_s0)
	);

	tb_slave_model #(.SALT(S1_SALT)) slave1 (
		.ACLK    (ACLK),
		.ARESETn (ARESETn),
		.araddr  (araddr_s1),
		.arid    (arid_s1),
		.arlen   (arlen_s1),
		.arvalid (arvalid_s1),
		.arready (arready_s1),
		.rid     (rid_s1),
		.rdata   (rdata_s1),
		.rresp   (rresp_s1),
		.rlast   (rlast_s1),
		.rvalid  (rvalid_s1),
		.rready  (rready_s1)
	);

	// ====================
	// Masters
	// ====================
	for (genvar g = 0; g < 2; g++) begin : gen_master
		addr_t  araddr;
		mid_t   arid;
		len_t   arlen;
		size_t  arsize;
		burst_t arburst;
		logic   arvalid;
		logic   rready;
		logic   issued_all;
		logic   done;
		beat_t  exp_q[$];
		logic   arready;
		mid_t   rid;
		data_t  rdata;
		resp_t  rresp;
		logic   rlast;
		logic   rvalid;

		assign arready = (g == 0) ? arready_m0 : arready_m1;
		assign rid     = (g == 0) ? rid_m0 : rid_m1;
		assign rdata   = (g == 0) ? rdata_m0 : rdata_m1;
		assign rresp   = (g == 0) ? rresp_m0 : rresp_m1;
		assign rlast   = (g == 0) ? rlast_m0 : rlast_m1;
		assign rvalid  = (g == 0) ? rvalid_m0 : rvalid_m1;

		initial begin : drive_reads
			int     n;
			int     k;
			addr_t  a;
			mid_t   id;
			len_t   len;
			size_t  sz;
			burst_t bt;
			araddr     <= '0;
			arid       <= '0;
			arlen      <= '0;
			arsize     <= '0;
			arburst    <= '0;
			arvalid    <= 1'b0;
			issued_all = 1'b0;
			wait (ARESETn === 1'b1);
			@(posedge ACLK);
			for (n = 0; n < READS_PER_MASTER; n++) begin
				// No gap on the first read so both masters contend
				while (n != 0 && ($urandom % 4) == 0) begin
					arvalid <= 1'b0;
					@(posedge ACLK);
				end
				a   = pick_addr(int'($urandom % 3));
				id  = mid_t'($urandom);
				len = len_t'($urandom % MAX_BEATS);
				// Size and burst only pass through to the slaves
				sz  = size_t'($urandom % 3);
				bt  = burst_t'($urandom % 2);
				for (k = 0; k <= int'(len); k++) begin
					exp_q.push_back(expected_beat(a, id, len, k));
				end
				araddr  <= a;
				arid    <= id;
				arlen   <= len;
				arsize  <= sz;
				arburst <= bt;
				arvalid <= 1'b1;
				@(posedge ACLK);
				while (!arready) begin
					@(posedge ACLK);
				end
			end
			arvalid    <= 1'b0;
			issued_all = 1'b1;
		end

		initial begin : check_beats
			beat_t exp;
			rready <= 1'b0;
			done   = 1'b0;
			forever begin
				@(posedge ACLK);
				if (ARESETn && rvalid && rready) begin
					if (exp_q.size() == 0) begin
						$display("Master %0d received a beat with no read outstanding", g);
						stop_on_failure();
					end
					exp = exp_q.pop_front();
					check_id(rid, exp.id, $sformatf("rid on master %0d", g));
					check_data(rdata, exp.data, $sformatf("rdata on master %0d", g));
					check_resp(rresp, exp.resp, $sformatf("rresp on master %0d", g));
					check_last(rlast, exp.last, $sformatf("rlast on master %0d", g));
					if (issued_all && exp_q.size() == 0) begin
						done = 1'b1;
					end
				end
				rready <= ($urandom % 3) != 0;
			end
		end
	end

	assign araddr_m0  = gen_master[0].araddr;
	assign arid_m0    = gen_master[0].arid;
	assign arlen_m0   = gen_master[0].arlen;
	assign arsize_m0  = gen_master[0].arsize;
	assign arburst_m0 = gen_master[0].arburst;
	assign arvalid_m0 = gen_master[0].arvalid;
	assign rready_m0  = gen_master[0].rready;
	assign araddr_m1  = gen_master[1].araddr;
	assign arid_m1    = gen_master[1].arid;
	assign arlen_m1   = gen_master[1].arlen;
	assign arsize_m1  = gen_master[1].arsize;
	assign arburst_m1 = gen_master[1].arburst;
	assign arvalid_m1 = gen_master[1].arvalid;
	assign rready_m1  = gen_master[1].rready;

	// ====================
	// Monitors
	// ====================
	initial begin : watch_ar
		logic   prio_m1;
		logic   win_m1;
		size_t  req_size;
		burst_t req_burst;
		prio_m1   = 1'b0;
		req_size  = '0;
		req_burst = '0;
		forever begin
			@(posedge ACLK);
			if (ARESETn) begin
				check_flag(arready_m0 && arready_m1, 1'b0, "both masters granted");
				if ((arvalid_m0 && arready_m0) || (arvalid_m1 && arready_m1)) begin
					win_m1 = arvalid_m1 && arready_m1;
					// Contended grant goes to the favoured master
					if (arvalid_m0 && arvalid_m1) begin
						check_flag(win_m1, prio_m1, "arbitration winner is master 1");
					end
					prio_m1   = !win_m1;
					req_size  = win_m1 ? arsize_m1 : arsize_m0;
					req_burst = win_m1 ? arburst_m1 : arburst_m0;
				end
				if (arvalid_s0 && arready_s0) begin
					if (araddr_s0 >= SLAVE1_BASE) begin
						$display("Slave 0 accepted address %h outside its range", araddr_s0);
						stop_on_failure();
					end
					check_size(arsize_s0, req_size, "arsize on slave 0");
					check_burst(arburst_s0, req_burst, "arburst on slave 0");
				end
				if (arvalid_s1 && arready_s1) begin
					if (araddr_s1 < SLAVE1_BASE || araddr_s1 >= DECODE_LIMIT) begin
						$display("Slave 1 accepted address %h outside its range", araddr_s1);
						stop_on_failure();
					end
					check_size(arsize_s1, req_size, "arsize on slave 1");
					check_burst(arburst_s1, req_burst, "arburst on slave 1");
				end
			end
		end
	end

	initial begin : watchdog
		int cycles;
		cycles = 0;
		forever begin
			@(posedge ACLK);
			cycles++;
			if (cycles >= TIMEOUT_CYCLES) begin
				$display("timeout: transactions did not complete");
				stop_on_failure();
			end
		end
	end

	initial begin : clock_gen
		ACLK = 1'b0;
		forever #(CLK_PERIOD / 2) ACLK = ~ACLK;
	end

	initial begin : main
		void'($urandom(SEED));
		ARESETn <= 1'b0;
		repeat (5) @(posedge ACLK);
		check_reset_levels();
		ARESETn <= 1'b1;
		@(posedge ACLK);
		check_reset_levels();
		while (!(gen_master[0].done && gen_master[1].done)) begin
			@(posedge ACLK);
		end
		// Drain a little so a stray beat still gets caught
		repeat (20) @(posedge ACLK);
		$display("sim passed");
		$finish;
	end

endmodule

//--- tests/tb_slave_model.sv
`timescale 1ns/10ps

module tb_slave_model #(
	parameter axi_pkg::data_t SALT = 32'h0000_0000
) (
	input  logic           ACLK,
	input  logic           ARESETn,

	input  axi_pkg::addr_t araddr,
	input  axi_pkg::sid_t  arid,
	input  axi_pkg::len_t  arlen,
	input  logic           arvalid,
	output logic           arready,

	output axi_pkg::sid_t  rid,
	output axi_pkg::data_t rdata,
	output axi_pkg::resp_t rresp,
	output logic           rlast,
	output logic           rvalid,
	input  logic           rready
);
	import axi_pkg::*;

	logic  busy;
	addr_t base;
	sid_t  id_q;
	len_t  last_idx;
	len_t  idx;

	// Beat data is the beat address with the salt applied
	assign rid   = id_q;
	assign rdata = (base + addr_t'(BEAT_BYTES) * addr_t'(idx)) ^ SALT;
	assign rresp = RESP_OKAY;
	assign rlast = (idx == last_idx);

	always @(posedge ACLK or negedge ARESETn) begin
		if (!ARESETn) begin
			arready  <= 1'b0;
			rvalid   <= 1'b0;
			busy     <= 1'b0;
			base     <= '0;
			id_q     <= '0;
			last_idx <= '0;
			idx      <= '0;
		end else if (!busy) begin
			if (arvalid && arready) begin
				arready  <= 1'b0;
				busy     <= 1'b1;
				base     <= araddr;
				id_q     <= arid;
				last_idx <= arlen;
				idx      <= '0;
				rvalid   <= ($urandom % 2) == 0;
			end else begin
				arready <= ($urandom % 3) == 0;
			end
		end else if (rvalid && rready) begin
			if (rlast) begin
				busy   <= 1'b0;
				rvalid <= 1'b0;
			end else begin
				idx    <= idx + 1'b1;
				rvalid <= ($urandom % 3) != 0;
			end
		end else if (!rvalid) begin
			rvalid <= ($urandom % 2) == 0;
		end
	end

endmodule

//--- rtl/axi_rd_xbar.sv
`timescale 1ns/10ps

module axi_rd_xbar #(
	parameter axi_pkg::addr_t SLAVE1_BASE  = 32'h0001_0000,
	parameter axi_pkg::addr_t DECODE_LIMIT = 32'h0002_0000
) (
	input  logic            ACLK,
	input  logic            ARESETn,

	// ====================
	// Master 0
	// ====================
	input  axi_pkg::addr_t  araddr_m0,
	input  axi_pkg::mid_t   arid_m0,
	input  axi_pkg::len_t   arlen_m0,
	input  axi_pkg::size_t  arsize_m0,
	input  axi_pkg::burst_t arburst_m0,
	input  logic            arvalid_m0,
	output logic            arready_m0,
	output axi_pkg::mid_t   rid_m0,
	output axi_pkg::data_t  rdata_m0,
	output axi_pkg::resp_t  rresp_m0,
	output logic            rlast_m0,
	output logic            rvalid_m0,
	input  logic            rready_m0,

	// ====================
	// Master 1
	// ====================
	input  axi_pkg::addr_t  araddr_m1,
	input  axi_pkg::mid_t   arid_m1,
	input  axi_pkg::len_t   arlen_m1,
	input  axi_pkg::size_t  arsize_m1,
	input  axi_pkg::burst_t arburst_m1,
	input  logic            arvalid_m1,
	output logic            arready_m1,
	output axi_pkg::mid_t   rid_m1,
	output axi_pkg::data_t  rdata_m1,
	output axi_pkg::resp_t  rresp_m1,
	output logic            rlast_m1,
	output logic            rvalid_m1,
	input  logic            rready_m1,

	// ====================
	// Slave 0
	// ====================
	output axi_pkg::addr_t  araddr_s0,
	output axi_pkg::sid_t   arid_s0,
	output axi_pkg::len_t   arlen_s0,
	output axi_pkg::size_t  arsize_s0,
	output axi_pkg::burst_t arburst_s0,
	output logic            arvalid_s0,
	input  logic            arready_s0,
	input  axi_pkg::sid_t   rid_s0,
	input  axi_pkg::data_t  rdata_s0,
	input  axi_pkg::resp_t  rresp_s0,
	input  logic            rlast_s0,
	input  logic            rvalid_s0,
	output logic            rready_s0,

	// ====================
	// Slave 1
	// ====================
	output axi_pkg::addr_t  araddr_s1,
	output axi_pkg::sid_t   arid_s1,
	output axi_pkg::len_t   arlen_s1,
	output axi_pkg::size_t  arsize_s1,
	output axi_pkg::burst_t arburst_s1,
	output logic            arvalid_s1,
	input  logic            arready_s1,
	input  axi_pkg::sid_t   rid_s1,
	input  axi_pkg::data_t  rdata_s1,
	input  axi_pkg::resp_t  rresp_s1,
	input  logic            rlast_s1,
	input  logic            rvalid_s1,
	output logic            rready_s1
);
	import axi_pkg::*;
	import xbar_pkg::*;

	logic    take;
	logic    take_m1;
	logic    issued;
	logic    burst_done;
	target_t target;

	addr_t   araddr_s;
	sid_t    arid_s;
	len_t    arlen_s;
	size_t   arsize_s;
	burst_t  arburst_s;

	// Internal decode-error slave
	logic    arvalid_de;
	logic    arready_de;
	sid_t    rid_de;
	data_t   rdata_de;
	resp_t   rresp_de;
	logic    rlast_de;
	logic    rvalid_de;
	logic    rready_de;

	// Both slaves see the same request fields
	assign araddr_s0  = araddr_s;
	assign arid_s0    = arid_s;
	assign arlen_s0   = arlen_s;
	assign arsize_s0  = arsize_s;
	assign arburst_s0 = arburst_s;
	assign araddr_s1  = araddr_s;
	assign arid_s1    = arid_s;
	assign arlen_s1   = arlen_s;
	assign arsize_s1  = arsize_s;
	assign arburst_s1 = arburst_s;

	ar_arbiter u_arbiter (
		.ACLK       (ACLK),
		.ARESETn    (ARESETn),
		.arvalid_m0 (arvalid_m0),
		.arvalid_m1 (arvalid_m1),
		.burst_done (burst_done),
		.grant_m0   (arready_m0),
		.grant_m1   (arready_m1),
		.take       (take),
		.take_m1    (take_m1)
	);

	ar_issue #(
		.SLAVE1_BASE  (SLAVE1_BASE),
		.DECODE_LIMIT (DECODE_LIMIT)
	) u_issue (
		.ACLK       (ACLK),
		.ARESETn    (ARESETn),
		.take       (take),
		.take_m1    (take_m1),
		.araddr_m0  (araddr_m0),
		.arid_m0    (arid_m0),
		.arlen_m0   (arlen_m0),
		.arsize_m0  (arsize_m0),
		.arburst_m0 (arburst_m0),
		.araddr_m1  (araddr_m1),
		.arid_m1    (arid_m1),
		.arlen_m1   (arlen_m1),
		.arsize_m1  (arsize_m1),
		.arburst_m1 (arburst_m1),
		.araddr_s   (araddr_s),
		.arid_s     (arid_s),
		.arlen_s    (arlen_s),
		.arsize_s   (arsize_s),
		.arburst_s  (arburst_s),
		.arvalid_s0 (arvalid_s0),
		.arvalid_s1 (arvalid_s1),
		.arvalid_de (arvalid_de),
		.arready_s0 (arready_s0),
		.arready_s1 (arready_s1),
		.arready_de (arready_de),
		.issued     (issued),
		.target     (target)
	);

	decerr_slave u_decerr (
		.ACLK    (ACLK),
		.ARESETn (ARESETn),
		.arvalid (arvalid_de),
		.arid    (arid_s),
		.arlen   (arlen_s),
		.arready (arready_de),
		.rid     (rid_de),
		.rdata   (rdata_de),
		.rresp   (rresp_de),
		.rlast   (rlast_de),
		.rvalid  (rvalid_de),
		.rready  (rready_de)
	);

	r_router u_router (
		.ACLK       (ACLK),
		.ARESETn    (ARESETn),
		.issued     (issued),
		.target     (target),
		.rid_s0     (rid_s0),
		.rdata_s0   (rdata_s0),
		.rresp_s0   (rresp_s0),
		.rlast_s0   (rlast_s0),
		.rvalid_s0  (rvalid_s0),
		.rready_s0  (rready_s0),
		.rid_s1     (rid_s1),
		.rdata_s1   (rdata_s1),
		.rresp_s1   (rresp_s1),
		.rlast_s1   (rlast_s1),
		.rvalid_s1  (rvalid_s1),
		.rready_s1  (rready_s1),
		.rid_de     (rid_de),
		.rdata_de   (rdata_de),
		.rresp_de   (rresp_de),
		.rlast_de   (rlast_de),
		.rvalid_de  (rvalid_de),
		.rready_de  (rready_de),
		.rid_m0     (rid_m0),
		.rdata_m0   (rdata_m0),
		.rresp_m0   (rresp_m0),
		.rlast_m0   (rlast_m0),
		.rvalid_m0  (rvalid_m0),
		.rready_m0  (rready_m0),
		.rid_m1     (rid_m1),
		.rdata_m1   (rdata_m1),
		.rresp_m1   (rresp_m1),
		.rlast_m1   (rlast_m1),
		.rvalid_m1  (rvalid_m1),
		.rready_m1  (rready_m1),
		.burst_done (burst_done)
	);

endmodule

//--- rtl/r_router.sv
`timescale 1ns/10ps

module r_router (
	input  logic              ACLK,
	input  logic              ARESETn,
	input  logic              issued,
	input  xbar_pkg::target_t target,

	input  axi_pkg::sid_t     rid_s0,
	input  axi_pkg::data_t    rdata_s0,
	input  axi_pkg::resp_t    rresp_s0,
	input  logic              rlast_s0,
	input  logic              rvalid_s0,
	output logic              rready_s0,

	input  axi_pkg::sid_t     rid_s1,
	input  axi_pkg::data_t    rdata_s1,
	input  axi_pkg::resp_t    rresp_s1,
	input  logic              rlast_s1,
	input  logic              rvalid_s1,
	output logic              rready_s1,

	input  axi_pkg::sid_t     rid_de,
	input  axi_pkg::data_t    rdata_de,
	input  axi_pkg::resp_t    rresp_de,
	input  logic              rlast_de,
	input  logic              rvalid_de,
	output logic              rready_de,

	output axi_pkg::mid_t     rid_m0,
	output axi_pkg::data_t    rdata_m0,
	output axi_pkg::resp_t    rresp_m0,
	output logic              rlast_m0,
	output logic              rvalid_m0,
	input  logic              rready_m0,

	output axi_pkg::mid_t     rid_m1,
	output axi_pkg::data_t    rdata_m1,
	output axi_pkg::resp_t    rresp_m1,
	output logic              rlast_m1,
	output logic              rvalid_m1,
	input  logic              rready_m1,

	output logic              burst_done
);
	import axi_pkg::*;
	import xbar_pkg::*;

	route_state_t      state;
	sid_t              sel_rid;
	data_t             sel_rdata;
	resp_t             sel_rresp;
	logic              sel_rlast;
	logic              sel_rvalid;
	sid_t              buf_id;
	data_t             buf_data;
	resp_t             buf_resp;
	logic              buf_last;
	logic [MIDX_W-1:0] buf_midx;
	logic              fetch_hs;
	logic              deliver_hs;

	// ====================
	// Slave side
	// ====================
	always_comb begin
		case (target)
			TGT_S0: begin
				sel_rid    = rid_s0;
				sel_rdata  = rdata_s0;
				sel_rresp  = rresp_s0;
				sel_rlast  = rlast_s0;
				sel_rvalid = rvalid_s0;
			end
			TGT_S1: begin
				sel_rid    = rid_s1;
				sel_rdata  = rdata_s1;
				sel_rresp  = rresp_s1;
				sel_rlast  = rlast_s1;
				sel_rvalid = rvalid_s1;
			end
			default: begin
				sel_rid    = rid_de;
				sel_rdata  = rdata_de;
				sel_rresp  = rresp_de;
				sel_rlast  = rlast_de;
				sel_rvalid = rvalid_de;
			end
		endcase
	end

	assign rready_s0 = (state == RT_FETCH) && (target == TGT_S0);
	assign rready_s1 = (state == RT_FETCH) && (target == TGT_S1);
	assign rready_de = (state == RT_FETCH) && (target == TGT_DECERR);

	assign fetch_hs = (state == RT_FETCH) && sel_rvalid;

	// One-beat buffer
	always_ff @(posedge ACLK) begin
		if (fetch_hs) begin
			buf_id   <= sel_rid;
			buf_data <= sel_rdata;
			buf_resp <= sel_rresp;
			buf_last <= sel_rlast;
		end
	end

	// ====================
	// Master side
	// ====================
	assign buf_midx = buf_id[SID_W-1 -: MIDX_W];

	assign rvalid_m0 = (state == RT_DELIVER) && (buf_midx == MIDX_M0);
	assign rvalid_m1 = (state == RT_DELIVER) && (buf_midx == MIDX_M1);

	assign rid_m0   = buf_id[MID_W-1:0];
	assign rdata_m0 = buf_data;
	assign rresp_m0 = buf_resp;
	assign rlast_m0 = buf_last;
	assign rid_m1   = buf_id[MID_W-1:0];
	assign rdata_m1 = buf_data;
	assign rresp_m1 = buf_resp;
	assign rlast_m1 = buf_last;

	assign deliver_hs = (rvalid_m0 && rready_m0) || (rvalid_m1 && rready_m1);
	assign burst_done = deliver_hs && buf_last;

	always_ff @(posedge ACLK or negedge ARESETn) begin
		if (!ARESETn) begin
			state <= RT_IDLE;
		end else begin
			case (state)
				RT_IDLE: begin
					if (issued) begin
						state <= RT_FETCH;
					end
				end
				RT_FETCH: begin
					if (fetch_hs) begin
						state <= RT_DELIVER;
					end
				end
				RT_DELIVER: begin
					if (deliver_hs) begin
						state <= buf_last ? RT_IDLE : RT_FETCH;
					end
				end
				default: begin
					state <= RT_IDLE;
				end
			endcase
		end
	end

endmodule

//--- rtl/decerr_slave.sv
`timescale 1ns/10ps

module decerr_slave (
	input  logic           ACLK,
	input  logic           ARESETn,

	input  logic           arvalid,
	input  axi_pkg::sid_t  arid,
	input  axi_pkg::len_t  arlen,
	output logic           arready,

	output axi_pkg::sid_t  rid,
	output axi_pkg::data_t rdata,
	output axi_pkg::resp_t rresp,
	output logic           rlast,
	output logic           rvalid,
	input  logic           rready
);
	import axi_pkg::*;

	logic busy;
	len_t remain;
	sid_t id_q;

	assign arready = arvalid && !busy;

	assign rvalid = busy;
	assign rid    = id_q;
	assign rdata  = '0;
	assign rresp  = RESP_DECERR;
	assign rlast  = (remain == '0);

	always_ff @(posedge ACLK or negedge ARESETn) begin
		if (!ARESETn) begin
			busy   <= 1'b0;
			remain <= '0;
		end else if (arvalid && arready) begin
			busy   <= 1'b1;
			remain <= arlen;
		end else if (rvalid && rready) begin
			// Count down the beats still owed
			if (remain == '0) begin
				busy <= 1'b0;
			end else begin
				remain <= remain - 1'b1;
			end
		end
	end

	always_ff @(posedge ACLK) begin
		if (arvalid && arready) begin
			id_q <= arid;
		end
	end

endmodule

//--- rtl/ar_issue.sv
`timescale 1ns/10ps

module ar_issue #(
	parameter axi_pkg::addr_t SLAVE1_BASE  = 32'h0001_0000,
	parameter axi_pkg::addr_t DECODE_LIMIT = 32'h0002_0000
) (
	input  logic              ACLK,
	input  logic              ARESETn,
	input  logic              take,
	input  logic              take_m1,

	input  axi_pkg::addr_t    araddr_m0,
	input  axi_pkg::mid_t     arid_m0,
	input  axi_pkg::len_t     arlen_m0,
	input  axi_pkg::size_t    arsize_m0,
	input  axi_pkg::burst_t   arburst_m0,

	input  axi_pkg::addr_t    araddr_m1,
	input  axi_pkg::mid_t     arid_m1,
	input  axi_pkg::len_t     arlen_m1,
	input  axi_pkg::size_t    arsize_m1,
	input  axi_pkg::burst_t   arburst_m1,

	output axi_pkg::addr_t    araddr_s,
	output axi_pkg::sid_t     arid_s,
	output axi_pkg::len_t     arlen_s,
	output axi_pkg::size_t    arsize_s,
	output axi_pkg::burst_t   arburst_s,

	output logic              arvalid_s0,
	output logic              arvalid_s1,
	output logic              arvalid_de,
	input  logic              arready_s0,
	input  logic              arready_s1,
	input  logic              arready_de,

	output logic              issued,
	output xbar_pkg::target_t target
);
	import axi_pkg::*;
	import xbar_pkg::*;

	addr_t   sel_addr;
	target_t sel_target;
	logic    pending;

	assign sel_addr = take_m1 ? araddr_m1 : araddr_m0;

	// Address map
	always_comb begin
		if (sel_addr < SLAVE1_BASE) begin
			sel_target = TGT_S0;
		end else if (sel_addr < DECODE_LIMIT) begin
			sel_target = TGT_S1;
		end else begin
			sel_target = TGT_DECERR;
		end
	end

	always_ff @(posedge ACLK) begin
		if (take) begin
			araddr_s  <= sel_addr;
			arid_s    <= take_m1 ? {MIDX_M1, arid_m1} : {MIDX_M0, arid_m0};
			arlen_s   <= take_m1 ? arlen_m1 : arlen_m0;
			arsize_s  <= take_m1 ? arsize_m1 : arsize_m0;
			arburst_s <= take_m1 ? arburst_m1 : arburst_m0;
		end
	end

	always_ff @(posedge ACLK or negedge ARESETn) begin
		if (!ARESETn) begin
			pending <= 1'b0;
			target  <= TGT_S0;
		end else if (take) begin
			pending <= 1'b1;
			target  <= sel_target;
		end else if (issued) begin
			pending <= 1'b0;
		end
	end

	// Only the decoded target sees ARVALID
	assign arvalid_s0 = pending && (target == TGT_S0);
	assign arvalid_s1 = pending && (target == TGT_S1);
	assign arvalid_de = pending && (target == TGT_DECERR);

	assign issued = (arvalid_s0 && arready_s0) ||
	                (arvalid_s1 && arready_s1) ||
	                (arvalid_de && arready_de);

endmodule

//--- rtl/ar_arbiter.sv
`timescale 1ns/10ps

module ar_arbiter (
	input  logic ACLK,
	input  logic ARESETn,

	input  logic arvalid_m0,
	input  logic arvalid_m1,
	input  logic burst_done,

	output logic grant_m0,
	output logic grant_m1,
	output logic take,
	output logic take_m1
);
	import xbar_pkg::*;

	arb_state_t state;
	logic       prio_m1;
	logic       owner_m1;
	logic       idle;

	assign idle = (state == ARB_IDLE);

	// Favoured master wins a tie, the other one only when alone
	assign grant_m0 = idle && arvalid_m0 && (!prio_m1 || !arvalid_m1);
	assign grant_m1 = idle && arvalid_m1 && (prio_m1 || !arvalid_m0);

	assign take    = grant_m0 || grant_m1;
	assign take_m1 = grant_m1;

	always_ff @(posedge ACLK or negedge ARESETn) begin
		if (!ARESETn) begin
			state <= ARB_IDLE;
		end else begin
			case (state)
				ARB_IDLE: begin
					if (take) begin
						state <= ARB_BUSY;
					end
				end
				ARB_BUSY: begin
					if (burst_done) begin
						state <= ARB_IDLE;
					end
				end
				default: begin
					state <= ARB_IDLE;
				end
			endcase
		end
	end

	// Remember who owns the burst in flight
	always_ff @(posedge ACLK or negedge ARESETn) begin
		if (!ARESETn) begin
			owner_m1 <= 1'b0;
		end else if (take) begin
			owner_m1 <= take_m1;
		end
	end

	// Other master is favoured once the burst ends
	always_ff @(posedge ACLK or negedge ARESETn) begin
		if (!ARESETn) begin
			prio_m1 <= 1'b0;
		end else if (burst_done) begin
			prio_m1 <= !owner_m1;
		end
	end

endmodule

//--- rtl/xbar_pkg.sv
package xbar_pkg;

	// ====================
	// Routing
	// ====================
	typedef enum logic [1:0] {
		TGT_S0,
		TGT_S1,
		TGT_DECERR
	} target_t;

	// ====================
	// State machines
	// ====================
	typedef enum logic {
		ARB_IDLE,
		ARB_BUSY
	} arb_state_t;

	typedef enum logic [1:0] {
		RT_IDLE,
		RT_FETCH,
		RT_DELIVER
	} route_state_t;

	// ====================
	// Slave ID layout
	// ====================
	// Upper nibble of the slave ID names the master
	localparam int MIDX_W = 4;

	localparam logic [MIDX_W-1:0] MIDX_M0 = 4'd0;
	localparam logic [MIDX_W-1:0] MIDX_M1 = 4'd1;

endpackage

//--- rtl/axi_pkg.sv
package axi_pkg;

	// ====================
	// Channel widths
	// ====================
	localparam int ADDR_W  = 32;
	localparam int DATA_W  = 32;
	localparam int MID_W   = 4;
	localparam int SID_W   = 8;
	localparam int LEN_W   = 8;
	localparam int SIZE_W  = 3;
	localparam int BURST_W = 2;
	localparam int RESP_W  = 2;

	typedef logic [ADDR_W-1:0]  addr_t;
	typedef logic [DATA_W-1:0]  data_t;
	typedef logic [MID_W-1:0]   mid_t;
	typedef logic [SID_W-1:0]   sid_t;
	typedef logic [LEN_W-1:0]   len_t;
	typedef logic [SIZE_W-1:0]  size_t;
	typedef logic [BURST_W-1:0] burst_t;
	typedef logic [RESP_W-1:0]  resp_t;

	// ====================
	// Response codes
	// ====================
	localparam resp_t RESP_OKAY   = 2'b00;
	localparam resp_t RESP_DECERR = 2'b11;

	// Bytes per data beat
	localparam int BEAT_BYTES = 4;

endpackage
